// File: fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

////////////////////////////////////////////////////////////
// bundle and datapath widths
////////////////////////////////////////////////////////////
`define FETCH_WIDTH      4    // slots per bundle
`define SIZE_PC          32
`define SIZE_INSTRUCTION 32
`define INST_BYTES       4    // address step between slots

////////////////////////////////////////////////////////////
// CTI queue
////////////////////////////////////////////////////////////
`define CTIQ_DEPTH       16
`define CTIQ_LOG         4    // tag width

////////////////////////////////////////////////////////////
// control-transfer opcodes
////////////////////////////////////////////////////////////
`define OP_JR            6'h08  // return
`define OP_JAL           6'h03  // call
`define OP_J             6'h02  // jump
`define OP_BEQ           6'h04
`define OP_BNE           6'h05

`endif

// File: fetchPkg.sv
`include "fetch_defines.svh"

package fetchPkg;

  typedef enum logic [1:0] {
    RETURN = 2'b00,
    CALL   = 2'b01,
    JUMP   = 2'b10,
    COND   = 2'b11
  } ctrlType_t;

  // one instruction word, seen as I-type or J-type
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } iForm;
    struct packed {
      logic [5:0]  opcode;
      logic [25:0] index;
    } jForm;
  } instWord_t;

  typedef struct packed {
    logic                btbHit;
    logic [`SIZE_PC-1:0] targetAddr;
    logic                prediction;  // predicted taken
  } slotPred_t;

  typedef struct packed {
    logic [`SIZE_INSTRUCTION-1:0] instruction;
    logic [`SIZE_PC-1:0]          pc;
    logic [`SIZE_PC-1:0]          targetAddr;
    logic [`CTIQ_LOG-1:0]         ctiqTag;
    logic                         prediction;
  } fetchPacket_t;

  typedef struct packed {
    logic [`CTIQ_LOG-1:0] ctiqIndex;
    logic [`SIZE_PC-1:0]  targetAddr;
    logic                 outcome;  // taken
  } resolve_t;

  typedef struct packed {
    logic [`SIZE_PC-1:0] pc;
    logic [`SIZE_PC-1:0] targetAddr;
    ctrlType_t           ctrlType;
    logic                dir;
  } btbUpdate_t;

endpackage

// File: preDecode.sv
`include "fetch_defines.svh"

module preDecode (
  input  logic [`SIZE_PC-1:0]  pc_i,
  input  fetchPkg::instWord_t  instruction_i,
  input  logic [`SIZE_PC-1:0]  btbTarget_i,
  output logic                 isCtrl_o,
  output fetchPkg::ctrlType_t  ctrlType_o,
  output logic [`SIZE_PC-1:0]  targetAddr_o
);

  logic [`SIZE_PC-1:0] branchOffset;
  logic [`SIZE_PC-1:0] jumpTarget;
  logic [`SIZE_PC-1:0] branchTarget;

  // word offset, sign extended and scaled by 4
  assign branchOffset = {{(`SIZE_PC-18){instruction_i.iForm.imm[15]}},
                         instruction_i.iForm.imm, 2'b00};
  assign branchTarget = pc_i + `INST_BYTES + branchOffset;

  // region of the current pc plus word index
  assign jumpTarget = {pc_i[`SIZE_PC-1:`SIZE_PC-4], instruction_i.jForm.index, 2'b00};

  always_comb begin
    isCtrl_o     = 1'b0;
    ctrlType_o   = fetchPkg::RETURN;
    targetAddr_o = pc_i + `INST_BYTES;  // fall-through
    case (instruction_i.iForm.opcode)
      `OP_JR: begin
        isCtrl_o     = 1'b1;
        ctrlType_o   = fetchPkg::RETURN;
        targetAddr_o = btbTarget_i;  // register target, only the BTB knows
      end
      `OP_JAL: begin
        isCtrl_o     = 1'b1;
        ctrlType_o   = fetchPkg::CALL;
        targetAddr_o = jumpTarget;
      end
      `OP_J: begin
        isCtrl_o     = 1'b1;
        ctrlType_o   = fetchPkg::JUMP;
        targetAddr_o = jumpTarget;
      end
      `OP_BEQ, `OP_BNE: begin
        isCtrl_o     = 1'b1;
        ctrlType_o   = fetchPkg::COND;
        targetAddr_o = branchTarget;
      end
      default: ;
    endcase
  end

endmodule

// File: fetchRedirect.sv
`include "fetch_defines.svh"

module fetchRedirect (
  input  logic [`FETCH_WIDTH-1:0] isCtrl_i,
  input  fetchPkg::ctrlType_t     ctrlType_i    [`FETCH_WIDTH],
  input  logic [`SIZE_PC-1:0]     decTarget_i   [`FETCH_WIDTH],
  input  logic [`SIZE_PC-1:0]     slotPc_i      [`FETCH_WIDTH],
  input  fetchPkg::slotPred_t     slotPred_i    [`FETCH_WIDTH],
  input  logic [`SIZE_PC-1:0]     addrRAS_i,
  input  logic                    stall_i,
  input  logic                    ctiQueueFull_i,
  output logic [`FETCH_WIDTH-1:0] slotValid_o,
  output logic [`SIZE_PC-1:0]     finalTarget_o [`FETCH_WIDTH],
  output logic [`FETCH_WIDTH-1:0] allocVector_o,
  output logic                    flagRecoverID_o,
  output logic                    flagRtrID_o,
  output logic                    flagCallID_o,
  output logic [`SIZE_PC-1:0]     targetAddrID_o,
  output logic [`SIZE_PC-1:0]     callPCID_o
);

  localparam int slotIdxW = $clog2(`FETCH_WIDTH);

  logic [`FETCH_WIDTH-1:0] taken;
  logic                    found;     // some slot is taken
  logic [slotIdxW-1:0]     firstIdx;  // first taken slot
  logic                    btbMiss;

  ////////////////////////////////////////////////////////////
  // taken test and priority scan
  ////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      // unconditional CTIs are always taken
      taken[i] = isCtrl_i[i] &
                 (slotPred_i[i].prediction | (ctrlType_i[i] != fetchPkg::COND));
    end
  end

  always_comb begin
    found    = 1'b0;
    firstIdx = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      slotValid_o[i] = ~found;  // cut after first taken
      if (taken[i] && !found) begin
        found    = 1'b1;
        firstIdx = slotIdxW'(i);
      end
    end
  end

  assign allocVector_o = isCtrl_i & slotValid_o;

  ////////////////////////////////////////////////////////////
  // BTB check on the first taken CTI
  ////////////////////////////////////////////////////////////
  assign btbMiss = found & ~slotPred_i[firstIdx].btbHit;

  assign flagRecoverID_o = btbMiss & ~stall_i & ~ctiQueueFull_i;
  assign flagRtrID_o     = flagRecoverID_o & (ctrlType_i[firstIdx] == fetchPkg::RETURN);
  assign flagCallID_o    = flagRecoverID_o & (ctrlType_i[firstIdx] == fetchPkg::CALL);

  always_comb begin
    finalTarget_o = decTarget_i;
    if (flagRtrID_o) begin
      finalTarget_o[firstIdx] = addrRAS_i;  // return goes to RAS top
    end
  end

  assign targetAddrID_o = finalTarget_o[firstIdx];
  assign callPCID_o     = slotPc_i[firstIdx];  // pushed on the RAS by fetch 1

endmodule

// File: ctiQueue.sv
`include "fetch_defines.svh"

module ctiQueue (
  input  logic                    clk,
  input  logic                    rst_i,
  input  logic                    alloc_i,
  input  logic [`FETCH_WIDTH-1:0] allocVector_i,
  input  logic [`SIZE_PC-1:0]     slotPc_i   [`FETCH_WIDTH],
  input  fetchPkg::ctrlType_t     ctrlType_i [`FETCH_WIDTH],
  output logic [`CTIQ_LOG-1:0]    ctiqTag_o  [`FETCH_WIDTH],
  input  fetchPkg::resolve_t      resolve_i,
  input  logic                    ctrlVerified_i,
  input  logic                    flagRecoverEX_i,
  input  logic                    commitCti_i,
  output fetchPkg::btbUpdate_t    btbUpdate_o,
  output logic                    updateEn_o,
  output logic                    ctiQueueFull_o
);

  localparam int cntW = `CTIQ_LOG + 1;

  // entry storage
  logic [`SIZE_PC-1:0] pcQ     [`CTIQ_DEPTH];
  fetchPkg::ctrlType_t typeQ   [`CTIQ_DEPTH];
  logic [`SIZE_PC-1:0] targetQ [`CTIQ_DEPTH];
  logic                dirQ    [`CTIQ_DEPTH];

  logic [`CTIQ_LOG-1:0] headPtr;
  logic [`CTIQ_LOG-1:0] tailPtr;
  logic [cntW-1:0]      occupancy;
  logic [cntW-1:0]      numAlloc;
  logic [`CTIQ_LOG-1:0] rollDiff;
  logic [cntW-1:0]      rolledCount;
  logic                 rollback;

  ////////////////////////////////////////////////////////////
  // tag assignment in slot order from the tail
  ////////////////////////////////////////////////////////////
  always_comb begin
    numAlloc = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      ctiqTag_o[i] = tailPtr + numAlloc[`CTIQ_LOG-1:0];
      if (allocVector_i[i]) begin
        numAlloc = numAlloc + 1'b1;
      end
    end
  end

  // fewer than a full bundle of free entries
  assign ctiQueueFull_o = occupancy > cntW'(`CTIQ_DEPTH - `FETCH_WIDTH);

  ////////////////////////////////////////////////////////////
  // rollback to the mispredicted CTI
  ////////////////////////////////////////////////////////////
  assign rollback = ctrlVerified_i & flagRecoverEX_i;
  assign rollDiff = resolve_i.ctiqIndex + 1'b1 - headPtr;

  // the resolved entry is live, so a zero distance is a full queue
  assign rolledCount = (rollDiff == '0) ? cntW'(`CTIQ_DEPTH) : {1'b0, rollDiff};

  always_ff @(posedge clk) begin
    if (rst_i) begin
      headPtr    <= '0;
      tailPtr    <= '0;
      occupancy  <= '0;
      updateEn_o <= 1'b0;
    end else begin
      updateEn_o <= commitCti_i;
      if (commitCti_i) begin
        headPtr <= headPtr + 1'b1;
      end
      if (rollback) begin
        tailPtr   <= resolve_i.ctiqIndex + 1'b1;
        occupancy <= rolledCount - cntW'(commitCti_i);
      end else begin
        if (alloc_i) begin
          tailPtr <= tailPtr + numAlloc[`CTIQ_LOG-1:0];
        end
        occupancy <= occupancy + (alloc_i ? numAlloc : '0) - cntW'(commitCti_i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // entry writes and commit read-out
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (alloc_i) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (allocVector_i[i]) begin
          pcQ[ctiqTag_o[i]]   <= slotPc_i[i];
          typeQ[ctiqTag_o[i]] <= ctrlType_i[i];
        end
      end
    end
    if (ctrlVerified_i) begin
      targetQ[resolve_i.ctiqIndex] <= resolve_i.targetAddr;
      dirQ[resolve_i.ctiqIndex]    <= resolve_i.outcome;
    end
    if (commitCti_i) begin
      btbUpdate_o.pc         <= pcQ[headPtr];
      btbUpdate_o.targetAddr <= targetQ[headPtr];
      btbUpdate_o.ctrlType   <= typeQ[headPtr];
      btbUpdate_o.dir        <= dirQ[headPtr];
    end
  end

endmodule

// File: fetchStage2.sv
`include "fetch_defines.svh"

module fetchStage2 (
  input  logic                                      clk,
  input  logic                                      rst_i,
  input  logic                                      stall_i,
  input  logic                                      fs1Ready_i,
  input  logic [`SIZE_PC-1:0]                       pc_i,
  input  logic [`FETCH_WIDTH*`SIZE_INSTRUCTION-1:0] instructionBundle_i,
  input  fetchPkg::slotPred_t                       slotPred_i   [`FETCH_WIDTH],
  input  logic [`SIZE_PC-1:0]                       addrRAS_i,
  input  fetchPkg::resolve_t                        resolve_i,
  input  logic                                      ctrlVerified_i,
  input  logic                                      flagRecoverEX_i,
  input  logic                                      commitCti_i,
  output fetchPkg::fetchPacket_t                    instPacket_o [`FETCH_WIDTH],
  output logic [`FETCH_WIDTH-1:0]                   instValid_o,
  output logic                                      flagRecoverID_o,
  output logic [`SIZE_PC-1:0]                       targetAddrID_o,
  output logic                                      flagRtrID_o,
  output logic                                      flagCallID_o,
  output logic [`SIZE_PC-1:0]                       callPCID_o,
  output fetchPkg::btbUpdate_t                      btbUpdate_o,
  output logic                                      updateEn_o,
  output logic                                      fs2Ready_o,
  output logic                                      ctiQueueFull_o
);

  logic [`SIZE_PC-1:0]     slotPc      [`FETCH_WIDTH];
  fetchPkg::instWord_t     slotInst    [`FETCH_WIDTH];
  logic [`FETCH_WIDTH-1:0] isCtrl;
  fetchPkg::ctrlType_t     ctrlType    [`FETCH_WIDTH];
  logic [`SIZE_PC-1:0]     decTarget   [`FETCH_WIDTH];
  logic [`SIZE_PC-1:0]     finalTarget [`FETCH_WIDTH];
  logic [`CTIQ_LOG-1:0]    ctiqTag     [`FETCH_WIDTH];
  logic [`FETCH_WIDTH-1:0] allocVector;
  logic                    allocEn;

  for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : gSlot
    assign slotPc[i]   = pc_i + `SIZE_PC'(`INST_BYTES * i);
    assign slotInst[i] = instructionBundle_i[i*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION];

    preDecode uPreDecode (
      .pc_i          (slotPc[i]),
      .instruction_i (slotInst[i]),
      .btbTarget_i   (slotPred_i[i].targetAddr),
      .isCtrl_o      (isCtrl[i]),
      .ctrlType_o    (ctrlType[i]),
      .targetAddr_o  (decTarget[i])
    );

    assign instPacket_o[i] = '{instruction: slotInst[i], pc: slotPc[i],
                               targetAddr: finalTarget[i], ctiqTag: ctiqTag[i],
                               prediction: slotPred_i[i].prediction};
  end

  fetchRedirect uRedirect (
    .isCtrl_i        (isCtrl),
    .ctrlType_i      (ctrlType),
    .decTarget_i     (decTarget),
    .slotPc_i        (slotPc),
    .slotPred_i      (slotPred_i),
    .addrRAS_i       (addrRAS_i),
    .stall_i         (stall_i),
    .ctiQueueFull_i  (ctiQueueFull_o),
    .slotValid_o     (instValid_o),
    .finalTarget_o   (finalTarget),
    .allocVector_o   (allocVector),
    .flagRecoverID_o (flagRecoverID_o),
    .flagRtrID_o     (flagRtrID_o),
    .flagCallID_o    (flagCallID_o),
    .targetAddrID_o  (targetAddrID_o),
    .callPCID_o      (callPCID_o)
  );

  assign allocEn = fs1Ready_i & ~stall_i & ~ctiQueueFull_o;  // bundle accepted

  ctiQueue uCtiQueue (
    .clk             (clk),
    .rst_i           (rst_i),
    .alloc_i         (allocEn),
    .allocVector_i   (allocVector),
    .slotPc_i        (slotPc),
    .ctrlType_i      (ctrlType),
    .ctiqTag_o       (ctiqTag),
    .resolve_i       (resolve_i),
    .ctrlVerified_i  (ctrlVerified_i),
    .flagRecoverEX_i (flagRecoverEX_i),
    .commitCti_i     (commitCti_i),
    .btbUpdate_o     (btbUpdate_o),
    .updateEn_o      (updateEn_o),
    .ctiQueueFull_o  (ctiQueueFull_o)
  );

  assign fs2Ready_o = fs1Ready_i & ~ctiQueueFull_o;

endmodule

// File: tb_fetchStage2.sv
`include "fetch_defines.svh"

module tb_fetchStage2;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int maxVec = 64;

  logic                                      clk = 1'b0;
  logic                                      rst_i;
  logic                                      stall_i;
  logic                                      fs1Ready_i;
  logic [`SIZE_PC-1:0]                       pc_i;
  logic [`FETCH_WIDTH*`SIZE_INSTRUCTION-1:0] instructionBundle_i;
  fetchPkg::slotPred_t                       slotPred_i   [`FETCH_WIDTH];
  logic [`SIZE_PC-1:0]                       addrRAS_i;
  fetchPkg::resolve_t                        resolve_i;
  logic                                      ctrlVerified_i;
  logic                                      flagRecoverEX_i;
  logic                                      commitCti_i;
  fetchPkg::fetchPacket_t                    instPacket_o [`FETCH_WIDTH];
  logic [`FETCH_WIDTH-1:0]                   instValid_o;
  logic                                      flagRecoverID_o;
  logic [`SIZE_PC-1:0]                       targetAddrID_o;
  logic                                      flagRtrID_o;
  logic                                      flagCallID_o;
  logic [`SIZE_PC-1:0]                       callPCID_o;
  fetchPkg::btbUpdate_t                      btbUpdate_o;
  logic                                      updateEn_o;
  logic                                      fs2Ready_o;
  logic                                      ctiQueueFull_o;

  logic [31:0] inF [maxVec][13];  // input columns
  logic [31:0] exF [maxVec][17];  // expected columns
  int          nVec = 0;
  int          errors = 0;
  int          cycles = 0;
  int          cycleLimit = 1000;

  fetchStage2 DUT (.*);

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic flagErr(string what, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic loadVectors();
    int    fd;
    int    n;
    string line;
    fd = $fopen("fetch_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file fetch_stimulus.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;
      if (line[0] == "I") begin
        n = $sscanf(line, "I %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    inF[nVec][0], inF[nVec][1], inF[nVec][2], inF[nVec][3],
                    inF[nVec][4], inF[nVec][5], inF[nVec][6], inF[nVec][7],
                    inF[nVec][8], inF[nVec][9], inF[nVec][10], inF[nVec][11],
                    inF[nVec][12]);
        if (n != 13) begin
          $display("malformed input line in stimulus file: %s", line);
          errors++;
        end
      end else if (line[0] == "E") begin
        n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    exF[nVec][0], exF[nVec][1], exF[nVec][2], exF[nVec][3],
                    exF[nVec][4], exF[nVec][5], exF[nVec][6], exF[nVec][7],
                    exF[nVec][8], exF[nVec][9], exF[nVec][10], exF[nVec][11],
                    exF[nVec][12], exF[nVec][13], exF[nVec][14], exF[nVec][15],
                    exF[nVec][16]);
        if (n != 17) begin
          $display("malformed expect line in stimulus file: %s", line);
          errors++;
        end
        nVec++;
      end
    end
    $fclose(fd);
  endtask

  task automatic driveVec(int v);
    logic [4:0] ctl;
    ctl = inF[v][9][4:0];
    pc_i = inF[v][0];
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      instructionBundle_i[s*`SIZE_INSTRUCTION +: `SIZE_INSTRUCTION] = inF[v][1+s];
      slotPred_i[s].btbHit     = inF[v][5][s];
      slotPred_i[s].prediction = inF[v][6][s];
      slotPred_i[s].targetAddr = inF[v][7];
    end
    addrRAS_i = inF[v][8];
    {stall_i, fs1Ready_i, ctrlVerified_i, flagRecoverEX_i, commitCti_i} = ctl;
    if (ctl[2]) begin
      resolve_i.ctiqIndex  = inF[v][10][`CTIQ_LOG-1:0];
      resolve_i.targetAddr = inF[v][11];
      resolve_i.outcome    = inF[v][12][0];
    end else begin
      resolve_i = fetchPkg::resolve_t'({$urandom, $urandom});  // unused this cycle
    end
  endtask

  task automatic checkVec(int v);
    logic [31:0] mask;
    int          ts;
    mask = exF[v][0];
    ts   = exF[v][8];
    for (int s = 0; s < `FETCH_WIDTH; s++) begin
      if (mask[0] && instPacket_o[s].pc !== inF[v][0] + 4 * s)
        flagErr($sformatf("vec %0d slot %0d pc", v, s), instPacket_o[s].pc, inF[v][0] + 4 * s);
      if (mask[0] && instPacket_o[s].instruction !== inF[v][1+s])
        flagErr($sformatf("vec %0d slot %0d inst", v, s), instPacket_o[s].instruction,
                inF[v][1+s]);
      if (mask[0] && instPacket_o[s].prediction !== inF[v][6][s])
        flagErr($sformatf("vec %0d slot %0d prediction", v, s), instPacket_o[s].prediction,
                inF[v][6][s]);
      if (mask[2] && instPacket_o[s].ctiqTag !== exF[v][7][4*s +: 4])
        flagErr($sformatf("vec %0d slot %0d tag", v, s), instPacket_o[s].ctiqTag,
                exF[v][7][4*s +: 4]);
    end
    if (mask[1] && instValid_o !== exF[v][1]) flagErr("instValid", instValid_o, exF[v][1]);
    if (mask[1] && flagRecoverID_o !== exF[v][2][0])
      flagErr("flagRecoverID", flagRecoverID_o, exF[v][2]);
    if (mask[1] && flagRtrID_o !== exF[v][3][0]) flagErr("flagRtrID", flagRtrID_o, exF[v][3]);
    if (mask[1] && flagCallID_o !== exF[v][4][0]) flagErr("flagCallID", flagCallID_o, exF[v][4]);
    if (mask[1] && exF[v][4][0] && callPCID_o !== exF[v][6])
      flagErr("callPCID", callPCID_o, exF[v][6]);
    if (mask[6] && targetAddrID_o !== exF[v][5])
      flagErr("targetAddrID", targetAddrID_o, exF[v][5]);
    if (mask[3] && instPacket_o[ts].targetAddr !== exF[v][9])
      flagErr($sformatf("slot %0d target", ts), instPacket_o[ts].targetAddr, exF[v][9]);
    if (ctiQueueFull_o !== exF[v][10][0]) flagErr("ctiQueueFull", ctiQueueFull_o, exF[v][10]);
    if (fs2Ready_o !== exF[v][11][0]) flagErr("fs2Ready", fs2Ready_o, exF[v][11]);
    if (updateEn_o !== exF[v][12][0]) flagErr("updateEn", updateEn_o, exF[v][12]);
    if (mask[5] && btbUpdate_o.pc !== exF[v][13]) flagErr("update pc", btbUpdate_o.pc, exF[v][13]);
    if (mask[5] && btbUpdate_o.targetAddr !== exF[v][14])
      flagErr("update target", btbUpdate_o.targetAddr, exF[v][14]);
    if (mask[5] && btbUpdate_o.ctrlType !== exF[v][15][1:0])
      flagErr("update type", btbUpdate_o.ctrlType, exF[v][15]);
    if (mask[5] && btbUpdate_o.dir !== exF[v][16][0])
      flagErr("update dir", btbUpdate_o.dir, exF[v][16]);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(71957));
    rst_i = 1'b1;
    stall_i = 1'b0;
    fs1Ready_i = 1'b0;
    pc_i = '0;
    instructionBundle_i = '0;
    for (int s = 0; s < `FETCH_WIDTH; s++) slotPred_i[s] = '0;
    addrRAS_i = '0;
    resolve_i = '0;
    ctrlVerified_i = 1'b0;
    flagRecoverEX_i = 1'b0;
    commitCti_i = 1'b0;
    loadVectors();
    cycleLimit = 4 * nVec + 50;
    repeat (3) @(posedge clk);
    #2 rst_i = 1'b0;
    for (int v = 0; v < nVec; v++) begin
      if (v > 0) begin
        @(posedge clk);
        #2;
      end
      driveVec(v);
      #16 checkVec(v);
    end
    $display("vectors %0d, errors %0d", nVec, errors);
    if (errors == 0 && nVec > 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: fetch_stimulus.txt
# I pc inst0 inst1 inst2 inst3 hitMask predMask btbTarget ras ctl(stall,fs1,ver,recEX,commit) resIdx resTarget resOut
# E mask valid rec rtr call targetID callPc tags(s3..s0) tgtSlot tgtVal full ready updEn updPc updTarget updType updDir
I 00001000 00000000 00000000 00000000 00000000 0 0 00000000 00000000 08 0 00000000 0
E 07 f 0 0 0 00000000 00000000 0000 0 00000000 0 1 0 00000000 00000000 0 0
I 00002000 10000010 00000000 08000800 1400fffe 4 0 00002000 00000000 08 0 00000000 0
E 4f 7 0 0 0 00002000 00000000 2110 0 00002044 0 1 0 00000000 00000000 0 0
I 00003000 00000000 20000000 00000000 00000000 0 0 0000aaa0 00005554 08 0 00000000 0
E 4f 3 1 1 0 00005554 00000000 3322 1 00005554 0 1 0 00000000 00000000 0 0
I 00004000 0c000c00 00000000 00000000 00000000 0 0 00000000 00000000 08 0 00000000 0
E 4f 1 1 0 1 00003000 00004000 4443 0 00003000 0 1 0 00000000 00000000 0 0
I 00005000 1400fffe 10000010 08000800 00000000 f 2 00000000 00000000 08 0 00000000 0
E 4f 3 0 0 0 00005048 00000000 6654 0 00004ffc 0 1 0 00000000 00000000 0 0
I 00006000 20000000 00000000 00000000 00000000 0 0 00000abc 00007000 1c 0 00002044 1
E 4f 1 0 0 0 00000abc 00000000 7776 0 00000abc 0 1 0 00000000 00000000 0 0
I 00007000 00000000 00000000 00000000 00000000 0 0 00000000 00000000 05 1 00002000 1
E 07 f 0 0 0 00000000 00000000 6666 0 00000000 0 0 0 00000000 00000000 0 0
I 00007010 00000000 00000000 00000000 00000000 0 0 00000000 00000000 01 0 00000000 0
E 27 f 0 0 0 00000000 00000000 6666 0 00000000 0 0 1 00002000 00002044 3 1
I 00007020 00000000 00000000 00000000 00000000 0 0 00000000 00000000 06 2 00005554 1
E 27 f 0 0 0 00000000 00000000 6666 0 00000000 0 0 1 00002008 00002000 2 1
I 00008000 10000010 10000010 10000010 10000010 0 0 00000000 00000000 08 0 00000000 0
E 07 f 0 0 0 00000000 00000000 6543 0 00000000 0 1 0 00000000 00000000 0 0
I 00009000 10000010 10000010 10000010 10000010 0 0 00000000 00000000 08 0 00000000 0
E 07 f 0 0 0 00000000 00000000 a987 0 00000000 0 1 0 00000000 00000000 0 0
I 0000a000 10000010 10000010 10000010 10000010 0 0 00000000 00000000 08 0 00000000 0
E 07 f 0 0 0 00000000 00000000 edcb 0 00000000 0 1 0 00000000 00000000 0 0
I 0000b000 20000000 00000000 00000000 00000000 0 0 0000bee0 00007000 08 0 00000000 0
E 4f 1 0 0 0 0000bee0 00000000 000f 0 0000bee0 1 0 0 00000000 00000000 0 0

// File: flist.f
+incdir+.
fetchPkg.sv
preDecode.sv
fetchRedirect.sv
ctiQueue.sv
fetchStage2.sv
tb_fetchStage2.sv

// File: Bender.yml
package:
  name: fetch_stage2

export_include_dirs:
  - .

sources:
  - fetchPkg.sv
  - preDecode.sv
  - fetchRedirect.sv
  - ctiQueue.sv
  - fetchStage2.sv
  - target: simulation
    files:
      - tb_fetchStage2.sv
